// File: logic/apb_ctrl.sv
`timescale 1ns/1ps

module apb_ctrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [periph_pkg::ADDR_W-1:0]   paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [periph_pkg::DATA_W-1:0]   pwdata,
  output logic                            pready,
  output logic [periph_pkg::DATA_W-1:0]   prdata,
  output logic                            pslverr,
  output periph_pkg::reg_id_e             reg_id,
  output logic [periph_pkg::DATA_W-1:0]   wdata,
  output logic                            spi_we,
  output logic                            gpio_we,
  input  logic [periph_pkg::DATA_W-1:0]   spi_rdata,
  input  logic [periph_pkg::DATA_W-1:0]   gpio_rdata
);

  import periph_pkg::*;

  logic setup_q;
  logic access;
  logic is_spi;
  logic is_gpio;

  // remembers that the previous cycle was a setup phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel & ~penable;
    end
  end

  // only an access phase that follows a setup phase counts
  assign access = psel & penable & setup_q;

  // address map
  always_comb begin
    case (paddr)
      SPI_CTRL_OFF:      reg_id = SPI_CTRL;
      SPI_TXDATA_OFF:    reg_id = SPI_TXDATA;
      SPI_RXDATA_OFF:    reg_id = SPI_RXDATA;
      SPI_STATUS_OFF:    reg_id = SPI_STATUS;
      GPIO_OUT_OFF:      reg_id = GPIO_OUT;
      GPIO_OE_OFF:       reg_id = GPIO_OE;
      GPIO_IN_OFF:       reg_id = GPIO_IN;
      GPIO_IRQ_EN_OFF:   reg_id = GPIO_IRQ_EN;
      GPIO_IRQ_STAT_OFF: reg_id = GPIO_IRQ_STAT;
      default:           reg_id = REG_NONE;
    endcase
  end

  assign is_spi  = reg_id inside {SPI_CTRL, SPI_TXDATA, SPI_RXDATA, SPI_STATUS};
  assign is_gpio = reg_id inside {GPIO_OUT, GPIO_OE, GPIO_IN, GPIO_IRQ_EN, GPIO_IRQ_STAT};

  // write strobes go to the owning block only
  assign wdata   = pwdata;
  assign spi_we  = access & pwrite & is_spi;
  assign gpio_we = access & pwrite & is_gpio;

  // no wait states
  assign pready = 1'b1;

  always_comb begin
    if (is_spi) begin
      prdata = spi_rdata;
    end else if (is_gpio) begin
      prdata = gpio_rdata;
    end else begin
      prdata = '0;
    end
  end

  assign pslverr = access & (reg_id == REG_NONE);

endmodule

// File: logic/gpio_block.sv
`timescale 1ns/1ps

module gpio_block #(
  parameter int GPIO_W = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  periph_pkg::reg_id_e           reg_id,
  input  logic [periph_pkg::DATA_W-1:0] wdata,
  input  logic                          we,
  output logic [periph_pkg::DATA_W-1:0] rdata,
  input  logic [GPIO_W-1:0]             gpio_i,
  output logic [GPIO_W-1:0]             gpio_o,
  output logic [GPIO_W-1:0]             gpio_oe,
  input  logic                          spi_done,
  output logic                          irq
);

  import periph_pkg::*;

  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;
  logic              done_prev_q;
  logic [GPIO_W:0]   irq_en_q;
  logic [GPIO_W:0]   irq_stat_q;
  logic [GPIO_W:0]   irq_set;
  logic [GPIO_W:0]   irq_clr;

  // bit GPIO_W is the SPI completion source
  assign irq_set = {spi_done & ~done_prev_q, sync2_q & ~prev_q};
  assign irq_clr = (we && reg_id == GPIO_IRQ_STAT) ? wdata[GPIO_W:0] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_o      <= '0;
      gpio_oe     <= '0;
      sync1_q     <= '0;
      sync2_q     <= '0;
      prev_q      <= '0;
      done_prev_q <= 1'b0;
      irq_en_q    <= '0;
      irq_stat_q  <= '0;
      irq         <= 1'b0;
    end else begin
      sync1_q     <= gpio_i;
      sync2_q     <= sync1_q;
      prev_q      <= sync2_q;
      done_prev_q <= spi_done;

      if (we && reg_id == GPIO_OUT) begin
        gpio_o <= wdata[GPIO_W-1:0];
      end
      if (we && reg_id == GPIO_OE) begin
        gpio_oe <= wdata[GPIO_W-1:0];
      end
      if (we && reg_id == GPIO_IRQ_EN) begin
        irq_en_q <= wdata[GPIO_W:0];
      end

      // a new edge wins over a clear in the same cycle
      irq_stat_q <= (irq_stat_q & ~irq_clr) | irq_set;

      irq <= |(irq_stat_q & irq_en_q);
    end
  end

  always_comb begin
    case (reg_id)
      GPIO_OUT:      rdata = DATA_W'(gpio_o);
      GPIO_OE:       rdata = DATA_W'(gpio_oe);
      GPIO_IN:       rdata = DATA_W'(sync2_q);
      GPIO_IRQ_EN:   rdata = DATA_W'(irq_en_q);
      GPIO_IRQ_STAT: rdata = DATA_W'(irq_stat_q);
      default:       rdata = '0;
    endcase
  end

endmodule

// File: logic/periph_pkg.sv
package periph_pkg;

  // APB port widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  // chip select 0 is the flash, 1 is the SD card
  localparam int SPI_CS_NUM = 2;

  // register identifiers, decoded once in apb_ctrl
  typedef enum logic [3:0] {
    REG_NONE,
    SPI_CTRL,
    SPI_TXDATA,
    SPI_RXDATA,
    SPI_STATUS,
    GPIO_OUT,
    GPIO_OE,
    GPIO_IN,
    GPIO_IRQ_EN,
    GPIO_IRQ_STAT
  } reg_id_e;

  // byte offsets of the register map
  localparam logic [ADDR_W-1:0] SPI_CTRL_OFF      = 12'h000;
  localparam logic [ADDR_W-1:0] SPI_TXDATA_OFF    = 12'h004;
  localparam logic [ADDR_W-1:0] SPI_RXDATA_OFF    = 12'h008;
  localparam logic [ADDR_W-1:0] SPI_STATUS_OFF    = 12'h00C;
  localparam logic [ADDR_W-1:0] GPIO_OUT_OFF      = 12'h100;
  localparam logic [ADDR_W-1:0] GPIO_OE_OFF       = 12'h104;
  localparam logic [ADDR_W-1:0] GPIO_IN_OFF       = 12'h108;
  localparam logic [ADDR_W-1:0] GPIO_IRQ_EN_OFF   = 12'h10C;
  localparam logic [ADDR_W-1:0] GPIO_IRQ_STAT_OFF = 12'h110;

  // SPI shifter states
  typedef enum logic [1:0] {
    IDLE,
    LEAD,
    SHIFT
  } spi_state_e;

endpackage

// File: logic/periph_sub.sv
`timescale 1ns/1ps

module periph_sub #(
  parameter int GPIO_W = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // APB slave
  input  logic [periph_pkg::ADDR_W-1:0]     paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [periph_pkg::DATA_W-1:0]     pwdata,
  output logic                              pready,
  output logic [periph_pkg::DATA_W-1:0]     prdata,
  output logic                              pslverr,
  // SPI master
  output logic                              spi_clk,
  output logic [periph_pkg::SPI_CS_NUM-1:0] spi_cs,
  output logic                              spi_mosi,
  input  logic                              spi_miso,
  // GPIO pads
  input  logic [GPIO_W-1:0]                 gpio_i,
  output logic [GPIO_W-1:0]                 gpio_o,
  output logic [GPIO_W-1:0]                 gpio_oe,
  output logic                              irq
);

  import periph_pkg::*;

  reg_id_e             reg_id;
  logic [DATA_W-1:0]   wdata;
  logic                spi_we;
  logic                gpio_we;
  logic [DATA_W-1:0]   spi_rdata;
  logic [DATA_W-1:0]   gpio_rdata;
  logic                spi_done;

  apb_ctrl i_apb_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .pready     (pready),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .reg_id     (reg_id),
    .wdata      (wdata),
    .spi_we     (spi_we),
    .gpio_we    (gpio_we),
    .spi_rdata  (spi_rdata),
    .gpio_rdata (gpio_rdata)
  );

  spi_engine i_spi_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .reg_id   (reg_id),
    .wdata    (wdata),
    .we       (spi_we),
    .rdata    (spi_rdata),
    .spi_done (spi_done),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_cs   (spi_cs),
    .spi_miso (spi_miso)
  );

  // SPI completion is an interrupt source of the GPIO block
  gpio_block #(
    .GPIO_W (GPIO_W)
  ) i_gpio_block (
    .clk      (clk),
    .rst_n    (rst_n),
    .reg_id   (reg_id),
    .wdata    (wdata),
    .we       (gpio_we),
    .rdata    (gpio_rdata),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .gpio_oe  (gpio_oe),
    .spi_done (spi_done),
    .irq      (irq)
  );

endmodule

// File: logic/spi_engine.sv
`timescale 1ns/1ps

module spi_engine (
  input  logic                              clk,
  input  logic                              rst_n,
  input  periph_pkg::reg_id_e               reg_id,
  input  logic [periph_pkg::DATA_W-1:0]     wdata,
  input  logic                              we,
  output logic [periph_pkg::DATA_W-1:0]     rdata,
  output logic                              spi_done,
  output logic                              spi_clk,
  output logic                              spi_mosi,
  output logic [periph_pkg::SPI_CS_NUM-1:0] spi_cs,
  input  logic                              spi_miso
);

  import periph_pkg::*;

  spi_state_e  state_q;
  logic [7:0]  div_q;
  logic        cs_sel_q;
  logic [7:0]  rx_q;
  logic        done_q;
  logic [7:0]  cnt_q;
  logic [3:0]  bit_cnt_q;
  logic [7:0]  shift_q;
  logic        miso_q;

  logic        busy;
  logic        start;
  logic        half_end;
  logic        rise_evt;
  logic        fall_evt;
  logic        done_evt;

  assign busy     = (state_q != IDLE);
  assign start    = we && (reg_id == SPI_TXDATA) && !busy;
  assign half_end = (cnt_q == div_q);

  // spi_clk edges, each one ends a half period of DIV+1 cycles
  assign rise_evt = half_end && ((state_q == LEAD) ||
                    (state_q == SHIFT && !spi_clk && bit_cnt_q != 4'd8));
  assign fall_evt = half_end && (state_q == SHIFT) && spi_clk;
  // trailing half period after the 8th falling edge
  assign done_evt = half_end && (state_q == SHIFT) && !spi_clk && (bit_cnt_q == 4'd8);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      div_q     <= '0;
      cs_sel_q  <= 1'b0;
      rx_q      <= '0;
      done_q    <= 1'b0;
      cnt_q     <= '0;
      bit_cnt_q <= '0;
      spi_clk   <= 1'b0;
      spi_mosi  <= 1'b0;
      spi_cs    <= '1;
    end else begin
      // config is frozen while a byte is on the wire
      if (we && reg_id == SPI_CTRL && !busy) begin
        div_q    <= wdata[15:8];
        cs_sel_q <= wdata[0];
      end
      if (we && reg_id == SPI_STATUS && wdata[1]) begin
        done_q <= 1'b0;
      end

      case (state_q)
        IDLE: begin
          if (start) begin
            state_q   <= LEAD;
            cnt_q     <= '0;
            bit_cnt_q <= '0;
            spi_cs    <= ~(SPI_CS_NUM'(1) << cs_sel_q);
            // MSB must be valid before the first rising edge
            spi_mosi  <= wdata[7];
          end
        end
        default: begin
          if (half_end) begin
            cnt_q <= '0;
          end else begin
            cnt_q <= cnt_q + 8'd1;
          end
          if (rise_evt) begin
            spi_clk <= 1'b1;
            state_q <= SHIFT;
          end
          if (fall_evt) begin
            spi_clk   <= 1'b0;
            spi_mosi  <= shift_q[6];
            bit_cnt_q <= bit_cnt_q + 4'd1;
          end
          if (done_evt) begin
            state_q  <= IDLE;
            spi_cs   <= '1;
            spi_mosi <= 1'b0;
            rx_q     <= shift_q;
            done_q   <= 1'b1;
          end
        end
      endcase
    end
  end

  // one register shifts tx out and rx in
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= wdata[7:0];
    end else if (fall_evt) begin
      shift_q <= {shift_q[6:0], miso_q};
    end
    if (rise_evt) begin
      miso_q <= spi_miso;
    end
  end

  assign spi_done = done_q;

  always_comb begin
    case (reg_id)
      SPI_CTRL:   rdata = {16'b0, div_q, 7'b0, cs_sel_q};
      SPI_RXDATA: rdata = {24'b0, rx_q};
      SPI_STATUS: rdata = {30'b0, done_q, busy};
      default:    rdata = '0;
    endcase
  end

endmodule

// File: periph_sub.f
logic/periph_pkg.sv
logic/apb_ctrl.sv
logic/spi_engine.sv
logic/gpio_block.sv
logic/periph_sub.sv
sim/tb_periph_sub.sv

// File: run.sh
#!/bin/sh
# build and run the periph_sub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_periph_sub \
  -f periph_sub.f \
  -o tb_periph_sub
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/tb_periph_sub
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

// File: sim/tb_periph_sub.sv
`timescale 1ns/1ps

module tb_periph_sub;

  localparam int GPIO_W = 8;
  localparam int SPI_TIMEOUT = 400;
  localparam int POLL_LIMIT = 200;

  localparam logic [11:0] A_SPI_CTRL      = 12'h000;
  localparam logic [11:0] A_SPI_TXDATA    = 12'h004;
  localparam logic [11:0] A_SPI_RXDATA    = 12'h008;
  localparam logic [11:0] A_SPI_STATUS    = 12'h00C;
  localparam logic [11:0] A_GPIO_OUT      = 12'h100;
  localparam logic [11:0] A_GPIO_OE       = 12'h104;
  localparam logic [11:0] A_GPIO_IN       = 12'h108;
  localparam logic [11:0] A_GPIO_IRQ_EN   = 12'h10C;
  localparam logic [11:0] A_GPIO_IRQ_STAT = 12'h110;

  localparam logic [31:0] GPIO_MASK = (32'd1 << GPIO_W) - 32'd1;
  localparam logic [31:0] IRQ_MASK  = (32'd1 << (GPIO_W + 1)) - 32'd1;

  logic              clk;
  logic              rst_n;
  logic [11:0]       paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic              pready;
  logic [31:0]       prdata;
  logic              pslverr;
  logic              spi_clk;
  logic [1:0]        spi_cs;
  logic              spi_mosi;
  logic              spi_miso;
  logic [GPIO_W-1:0] gpio_i;
  logic [GPIO_W-1:0] gpio_o;
  logic [GPIO_W-1:0] gpio_oe;
  logic              irq;

  // register model kept in step by the test sequence
  logic [31:0] m_out;
  logic [31:0] m_oe;
  logic [31:0] m_in;
  logic [31:0] m_ctrl;
  logic [31:0] m_rx;
  logic        m_done;
  logic [31:0] m_irq_en;
  logic [31:0] m_irq_stat;

  logic [31:0] lfsr_q;
  logic [7:0]  captured_mosi;
  logic [11:0] mapped_addrs [9];

  periph_sub #(
    .GPIO_W (GPIO_W)
  ) i_periph_sub (.*);

  always #4 clk = ~clk;

  task automatic end_in_failure();
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_fail(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    end_in_failure();
  endtask

  task automatic timeout_fail(input string msg);
    $display("Timed out while waiting: %s", msg);
    end_in_failure();
  endtask

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = 32'h0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic addr_unmapped(input logic [11:0] addr);
    return !(addr inside {A_SPI_CTRL, A_SPI_TXDATA, A_SPI_RXDATA, A_SPI_STATUS, A_GPIO_OUT,
                          A_GPIO_OE, A_GPIO_IN, A_GPIO_IRQ_EN, A_GPIO_IRQ_STAT});
  endfunction

  // expected read data from the register map
  function automatic logic [31:0] expected_read(input logic [11:0] addr);
    case (addr)
      A_SPI_CTRL:      return m_ctrl;
      A_SPI_RXDATA:    return m_rx;
      A_SPI_STATUS:    return {30'h0, m_done, 1'b0};
      A_GPIO_OUT:      return m_out & GPIO_MASK;
      A_GPIO_OE:       return m_oe & GPIO_MASK;
      A_GPIO_IN:       return m_in & GPIO_MASK;
      A_GPIO_IRQ_EN:   return m_irq_en & IRQ_MASK;
      A_GPIO_IRQ_STAT: return m_irq_stat & IRQ_MASK;
      default:         return 32'h0;
    endcase
  endfunction

  function automatic logic expected_irq();
    return |(m_irq_stat & m_irq_en & IRQ_MASK);
  endfunction

  task automatic apb_access(input logic write, input logic [11:0] addr,
                            input logic [31:0] data, output logic [31:0] rd_data);
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rd_data = prdata;
    assert (pready === 1'b1) else check_fail("pready low in access cycle");
    assert (pslverr === addr_unmapped(addr))
      else check_fail($sformatf("pslverr %b at offset %h", pslverr, addr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic check_read(input logic [11:0] addr);
    logic [31:0] rd;
    apb_read(addr, rd);
    assert (rd === expected_read(addr))
      else check_fail($sformatf("read %h got %h, expected %h", addr, rd, expected_read(addr)));
  endtask

  // SPI slave sampled on falling clk edges where the pins are stable
  task automatic run_spi_slave(input int sel, input int div, input logic [7:0] miso_byte);
    logic [7:0] out_q;
    logic [1:0] cs_expect;
    logic       prev_clk;
    int         since;
    int         rises;
    int         waited;
    out_q         = miso_byte;
    cs_expect     = ~(2'b01 << sel);
    spi_miso      = out_q[7];
    captured_mosi = 8'h00;
    waited = 0;
    while (spi_cs === 2'b11) begin
      @(negedge clk);
      waited++;
      if (waited > SPI_TIMEOUT) timeout_fail("chip select never went low");
    end
    assert (spi_cs === cs_expect)
      else check_fail($sformatf("chip select %b, expected %b", spi_cs, cs_expect));
    prev_clk = 1'b0;
    since    = 0;
    rises    = 0;
    waited   = 0;
    while (spi_cs !== 2'b11) begin
      @(negedge clk);
      since++;
      waited++;
      if (waited > SPI_TIMEOUT) timeout_fail("chip select never went high");
      assert (spi_cs === cs_expect || spi_cs === 2'b11)
        else check_fail($sformatf("chip select %b during transfer", spi_cs));
      if (spi_clk !== prev_clk || spi_cs === 2'b11) begin
        assert (since == div + 1)
          else check_fail($sformatf("half period %0d cycles, expected %0d", since, div + 1));
        since = 0;
      end
      if (spi_clk === 1'b1 && prev_clk === 1'b0) begin
        captured_mosi = {captured_mosi[6:0], spi_mosi};
        rises++;
      end
      if (spi_clk === 1'b0 && prev_clk === 1'b1) begin
        out_q    = {out_q[6:0], 1'b0};
        spi_miso = out_q[7];
      end
      prev_clk = spi_clk;
    end
    assert (rises == 8) else check_fail($sformatf("%0d spi_clk rising edges", rises));
    assert (spi_clk === 1'b0) else check_fail("spi_clk high after chip select rose");
  endtask

  task automatic spi_transfer(input int sel, input int div);
    logic [31:0] tx;
    logic [31:0] rx;
    logic [31:0] status;
    int          polls;
    draw_bits(8, tx);
    draw_bits(8, rx);
    apb_write(A_SPI_CTRL, (32'(div) << 8) | 32'(sel));
    m_ctrl = ((32'(div) << 8) | 32'(sel)) & 32'h0000_FF01;
    check_read(A_SPI_CTRL);
    fork
      run_spi_slave(sel, div, rx[7:0]);
      begin
        apb_write(A_SPI_TXDATA, tx);
        polls = 0;
        do begin
          apb_read(A_SPI_STATUS, status);
          if (polls == 0) begin
            assert (status[0] === 1'b1) else check_fail("busy not set after TXDATA write");
          end
          polls++;
          if (polls > POLL_LIMIT) timeout_fail("busy never fell");
        end while (status[0] === 1'b1);
        assert (status[1] === 1'b1) else check_fail("done not set when busy fell");
      end
    join
    assert (captured_mosi === tx[7:0])
      else check_fail($sformatf("MOSI byte %h, expected %h", captured_mosi, tx[7:0]));
    m_rx       = {24'h0, rx[7:0]};
    m_done     = 1'b1;
    m_irq_stat = m_irq_stat | (32'd1 << GPIO_W);
    check_read(A_SPI_RXDATA);
    check_read(A_SPI_STATUS);
    apb_write(A_SPI_STATUS, 32'h2);
    m_done = 1'b0;
    check_read(A_SPI_STATUS);
  endtask

  // synchronizer plus edge detect takes three cycles
  task automatic raise_gpio_input(input int idx);
    @(negedge clk);
    gpio_i[idx] = 1'b1;
    m_in        = m_in | (32'd1 << idx);
    m_irq_stat  = m_irq_stat | (32'd1 << idx);
    repeat (3) @(negedge clk);
  endtask

  initial begin
    logic [31:0] val;
    clk        = 1'b0;
    rst_n      = 1'b0;
    paddr      = 12'h0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = 32'h0;
    spi_miso   = 1'b0;
    gpio_i     = '0;
    lfsr_q     = 32'ha656;
    m_out      = 32'h0;
    m_oe       = 32'h0;
    m_in       = 32'h0;
    m_ctrl     = 32'h0;
    m_rx       = 32'h0;
    m_done     = 1'b0;
    m_irq_en   = 32'h0;
    m_irq_stat = 32'h0;
    mapped_addrs = '{A_SPI_CTRL, A_SPI_TXDATA, A_SPI_RXDATA, A_SPI_STATUS, A_GPIO_OUT,
                     A_GPIO_OE, A_GPIO_IN, A_GPIO_IRQ_EN, A_GPIO_IRQ_STAT};
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // reset values
    assert (spi_cs === 2'b11 && spi_clk === 1'b0 && spi_mosi === 1'b0)
      else check_fail("SPI pins not idle after reset");
    assert (gpio_o === '0 && gpio_oe === '0 && irq === 1'b0)
      else check_fail("GPIO pins or irq not clear after reset");
    foreach (mapped_addrs[i]) check_read(mapped_addrs[i]);

    repeat (4) begin
      draw_bits(32, val);
      apb_write(A_GPIO_OUT, val);
      m_out = val & GPIO_MASK;
      assert (32'(gpio_o) === m_out) else check_fail($sformatf("gpio_o %h", gpio_o));
      check_read(A_GPIO_OUT);
      draw_bits(32, val);
      apb_write(A_GPIO_OE, val);
      m_oe = val & GPIO_MASK;
      assert (32'(gpio_oe) === m_oe) else check_fail($sformatf("gpio_oe %h", gpio_oe));
      check_read(A_GPIO_OE);
    end

    // rising inputs also latch status bits
    repeat (4) begin
      draw_bits(GPIO_W, val);
      @(negedge clk);
      m_irq_stat = m_irq_stat | (val & ~m_in);
      m_in       = val;
      gpio_i     = val[GPIO_W-1:0];
      repeat (3) @(negedge clk);
      check_read(A_GPIO_IN);
    end
    check_read(A_GPIO_IRQ_STAT);

    draw_bits(32, val);
    apb_write(12'h014, val);
    apb_write(12'h200, val);
    check_read(12'h014);
    check_read(12'h200);
    foreach (mapped_addrs[i]) check_read(mapped_addrs[i]);

    for (int sel = 0; sel < 2; sel++) begin
      repeat (3) begin
        draw_bits(2, val);
        spi_transfer(sel, int'(val));
      end
    end

    // interrupts
    @(negedge clk);
    gpio_i = '0;
    m_in   = 32'h0;
    repeat (3) @(negedge clk);
    apb_write(A_GPIO_IRQ_STAT, IRQ_MASK);
    m_irq_stat = 32'h0;
    apb_write(A_GPIO_IRQ_EN, 32'h1 | (32'h1 << GPIO_W));
    m_irq_en = 32'h1 | (32'h1 << GPIO_W);
    check_read(A_GPIO_IRQ_EN);
    check_read(A_GPIO_IRQ_STAT);
    raise_gpio_input(1);
    repeat (2) @(negedge clk);
    assert (irq === expected_irq()) else check_fail("irq raised by a disabled source");
    check_read(A_GPIO_IRQ_STAT);
    raise_gpio_input(0);
    repeat (2) @(negedge clk);
    assert (irq === expected_irq()) else check_fail("irq wrong after gpio_i[0] edge");
    check_read(A_GPIO_IRQ_STAT);
    // drop the gpio sources so only SPI completion can raise irq
    apb_write(A_GPIO_IRQ_STAT, 32'h3);
    m_irq_stat = m_irq_stat & ~32'h3;
    repeat (2) @(negedge clk);
    assert (irq === expected_irq()) else check_fail("irq still high after clearing gpio status");
    check_read(A_GPIO_IRQ_STAT);
    draw_bits(2, val);
    spi_transfer(0, int'(val));
    repeat (2) @(negedge clk);
    assert (irq === expected_irq()) else check_fail("irq wrong after SPI completion");
    check_read(A_GPIO_IRQ_STAT);
    apb_write(A_GPIO_IRQ_STAT, IRQ_MASK);
    m_irq_stat = 32'h0;
    repeat (2) @(negedge clk);
    assert (irq === expected_irq()) else check_fail("irq still high after clearing status");
    check_read(A_GPIO_IRQ_STAT);

    $display("All tests passed");
    $finish;
  end

endmodule
